//--- des_pkg.sv
// ---------------------------------------------------------------------------
// all permutation tables use DES numbering where bit 1 is the MSB of a word
// ---------------------------------------------------------------------------
package des_pkg;

	localparam int BLOCK_W = 64;
	localparam int HALF_W = 32;
	localparam int RKEY_W = 48;
	localparam int CD_W = 28;
	localparam int NUM_SBOXES = 8;
	localparam int NUM_ROUNDS = 16;

	// input register, IP register, sixteen rounds and the output register
	localparam int PIPE_LATENCY = 19;

	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [HALF_W-1:0] half_t;
	typedef logic [RKEY_W-1:0] round_key_t;
	typedef round_key_t round_keys_t [1:NUM_ROUNDS];

	typedef struct packed {
		logic  valid;
		half_t left;
		half_t right;
	} des_stage_t;

	localparam int unsigned IP_TABLE [BLOCK_W] = '{
		58, 50, 42, 34, 26, 18, 10, 2,
		60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6,
		64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1,
		59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5,
		63, 55, 47, 39, 31, 23, 15, 7
	};

	// inverse of IP
	localparam int unsigned FP_TABLE [BLOCK_W] = '{
		40, 8, 48, 16, 56, 24, 64, 32,
		39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30,
		37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28,
		35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26,
		33, 1, 41, 9, 49, 17, 57, 25
	};

	localparam int unsigned E_TABLE [RKEY_W] = '{
		32, 1, 2, 3, 4, 5,
		4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32, 1
	};

	localparam int unsigned P_TABLE [HALF_W] = '{
		16, 7, 20, 21, 29, 12, 28, 17,
		1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9,
		19, 13, 30, 6, 22, 11, 4, 25
	};

	// PC-1 skips every eighth key bit, which is parity
	localparam int unsigned PC1_TABLE [2*CD_W] = '{
		57, 49, 41, 33, 25, 17, 9,
		1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27,
		19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29,
		21, 13, 5, 28, 20, 12, 4
	};

	localparam int unsigned PC2_TABLE [RKEY_W] = '{
		14, 17, 11, 24, 1, 5,
		3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8,
		16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	// left rotation applied to C and D before each round
	localparam int unsigned SHIFT_TABLE [NUM_ROUNDS] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// each box is stored row major, so the index is {row, column}
	localparam logic [3:0] SBOX_TABLE [NUM_SBOXES][64] = '{
		'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
			0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
			4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
			15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
		'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
			3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
			0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
			13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
		'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
			13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
			13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
			1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
		'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
			13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
			10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
			3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
		'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
			14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
			4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
			11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
		'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
			10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
			9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
			4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
		'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
			13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
			1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
			6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
		'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
			1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
			7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
			2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
	};

endpackage

//--- des_key_schedule.sv
// ---------------------------------------------------------------------------
// purely combinational so the key must not change while blocks are in flight
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_key_schedule (
	input  des_pkg::block_t      key,
	output des_pkg::round_keys_t round_keys
);
	import des_pkg::*;

	logic [2*CD_W-1:0] pc1_out;

	// C ends up in the upper 28 bits and D in the lower 28
	always_comb begin
		for (int i = 0; i < 2*CD_W; i++) begin
			pc1_out[2*CD_W-1-i] = key[BLOCK_W - PC1_TABLE[i]];
		end
	end

	// the rotations accumulate from round to round
	always_comb begin : gen_round_keys
		logic [CD_W-1:0]   c;
		logic [CD_W-1:0]   d;
		logic [2*CD_W-1:0] cd;

		c = pc1_out[2*CD_W-1:CD_W];
		d = pc1_out[CD_W-1:0];
		for (int r = 1; r <= NUM_ROUNDS; r++) begin
			if (SHIFT_TABLE[r-1] == 1) begin
				c = {c[CD_W-2:0], c[CD_W-1]};
				d = {d[CD_W-2:0], d[CD_W-1]};
			end else begin
				c = {c[CD_W-3:0], c[CD_W-1:CD_W-2]};
				d = {d[CD_W-3:0], d[CD_W-1:CD_W-2]};
			end
			cd = {c, d};
			for (int j = 0; j < RKEY_W; j++) begin
				round_keys[r][RKEY_W-1-j] = cd[2*CD_W - PC2_TABLE[j]];
			end
		end
	end

endmodule

//--- des_feistel.sv
// ---------------------------------------------------------------------------
// combinational DES round function f(R, K)
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_feistel (
	input  des_pkg::half_t      right,
	input  des_pkg::round_key_t round_key,
	output des_pkg::half_t      f_out
);
	import des_pkg::*;

	round_key_t expanded;
	round_key_t mixed;
	half_t      sbox_out;

	// E duplicates the edge bits of every nibble to get 48 bits
	always_comb begin
		for (int i = 0; i < RKEY_W; i++) begin
			expanded[RKEY_W-1-i] = right[HALF_W - E_TABLE[i]];
		end
	end

	assign mixed = expanded ^ round_key;

	// outer bits of a group pick the row, inner four pick the column
	always_comb begin : sbox_lookup
		logic [5:0] grp;

		for (int b = 0; b < NUM_SBOXES; b++) begin
			grp = mixed[RKEY_W-1-6*b -: 6];
			sbox_out[HALF_W-1-4*b -: 4] = SBOX_TABLE[b][{grp[5], grp[0], grp[4:1]}];
		end
	end

	always_comb begin
		for (int i = 0; i < HALF_W; i++) begin
			f_out[HALF_W-1-i] = sbox_out[HALF_W - P_TABLE[i]];
		end
	end

endmodule

//--- des_round.sv
// ---------------------------------------------------------------------------
// one registered Feistel round with the data computed whatever valid is
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_round (
	input  logic                clock,
	input  logic                rst,
	input  des_pkg::round_key_t round_key,
	input  des_pkg::des_stage_t stage_in,
	output des_pkg::des_stage_t stage_out
);
	import des_pkg::*;

	half_t f_out;

	des_feistel i_feistel (
		.right     (stage_in.right),
		.round_key (round_key),
		.f_out     (f_out)
	);

	// L(n) = R(n-1) and R(n) = L(n-1) ^ f(R(n-1), K(n))
	always_ff @(posedge clock) begin
		if (rst) begin
			stage_out <= '0;
		end else begin
			stage_out.valid <= stage_in.valid;
			stage_out.left  <= stage_in.right;
			stage_out.right <= stage_in.left ^ f_out;
		end
	end

endmodule

//--- des_ip_stage.sv
// ---------------------------------------------------------------------------
// two register stages from the input pins to L0 and R0
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_ip_stage (
	input  logic                clock,
	input  logic                rst,
	input  des_pkg::block_t     plaintext,
	input  logic                iv,
	output des_pkg::des_stage_t stage_out
);
	import des_pkg::*;

	block_t in_block;
	logic   in_valid;
	block_t ip_block;

	// raw capture of the pins
	always_ff @(posedge clock) begin
		if (rst) begin
			in_block <= '0;
			in_valid <= 1'b0;
		end else begin
			in_block <= plaintext;
			in_valid <= iv;
		end
	end

	always_comb begin
		for (int i = 0; i < BLOCK_W; i++) begin
			ip_block[BLOCK_W-1-i] = in_block[BLOCK_W - IP_TABLE[i]];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			stage_out <= '0;
		end else begin
			stage_out.valid <= in_valid;
			stage_out.left  <= ip_block[BLOCK_W-1:HALF_W];
			stage_out.right <= ip_block[HALF_W-1:0];
		end
	end

endmodule

//--- des_fp_stage.sv
// ---------------------------------------------------------------------------
// final swap and inverse permutation into the output register
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_fp_stage (
	input  logic                clock,
	input  logic                rst,
	input  des_pkg::des_stage_t stage_in,
	output des_pkg::block_t     ciphertext,
	output logic                ov
);
	import des_pkg::*;

	block_t pre_output;
	block_t fp_block;

	// the sixteenth round also swaps, so R16 goes first
	assign pre_output = {stage_in.right, stage_in.left};

	always_comb begin
		for (int i = 0; i < BLOCK_W; i++) begin
			fp_block[BLOCK_W-1-i] = pre_output[BLOCK_W - FP_TABLE[i]];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ciphertext <= '0;
			ov         <= 1'b0;
		end else begin
			ciphertext <= fp_block;
			ov         <= stage_in.valid;
		end
	end

endmodule

//--- des_top.sv
// ---------------------------------------------------------------------------
// one block per cycle with no back-pressure and a fixed 19 cycle latency
// key changes corrupt every block still in the pipeline
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_top (
	input  logic            clock,
	input  logic            rst,
	input  des_pkg::block_t key,
	input  des_pkg::block_t plaintext,
	input  logic            iv,
	output des_pkg::block_t ciphertext,
	output logic            ov
);
	import des_pkg::*;

	round_keys_t round_keys;

	// stage[0] holds L0/R0 and stage[n] the output of round n
	des_stage_t stage [0:NUM_ROUNDS];

	des_key_schedule i_key_schedule (
		.key        (key),
		.round_keys (round_keys)
	);

	des_ip_stage i_ip_stage (
		.clock     (clock),
		.rst       (rst),
		.plaintext (plaintext),
		.iv        (iv),
		.stage_out (stage[0])
	);

	for (genvar n = 1; n <= NUM_ROUNDS; n++) begin : g_round
		des_round i_round (
			.clock     (clock),
			.rst       (rst),
			.round_key (round_keys[n]),
			.stage_in  (stage[n-1]),
			.stage_out (stage[n])
		);
	end

	des_fp_stage i_fp_stage (
		.clock      (clock),
		.rst        (rst),
		.stage_in   (stage[NUM_ROUNDS]),
		.ciphertext (ciphertext),
		.ov         (ov)
	);

endmodule

//--- des_assert.sv
// ---------------------------------------------------------------------------
// valid timing of des_top, needs PIPE_LATENCY cycles out of reset to arm
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_assert (
	input logic            clock,
	input logic            rst,
	input logic            iv,
	input logic            ov,
	input des_pkg::block_t ciphertext
);
	import des_pkg::*;

	// saturating count of edges since the last reset edge
	int unsigned run_cycles;

	always_ff @(posedge clock) begin
		if (rst) begin
			run_cycles <= 0;
		end else if (run_cycles < PIPE_LATENCY) begin
			run_cycles <= run_cycles + 1;
		end
	end

	a_reset_clears: assert property (@(posedge clock) rst |=> (!ov && ciphertext == '0))
		else $error("ov or ciphertext not cleared by reset");

	// data from before the reset must never leak out
	a_no_early_ov: assert property (@(posedge clock) disable iff (rst)
		(run_cycles < PIPE_LATENCY) |-> !ov)
		else $error("ov rose before the pipeline could hold a block");

	a_ov_follows_iv: assert property (@(posedge clock) disable iff (rst)
		(run_cycles == PIPE_LATENCY) |-> (ov == $past(iv, PIPE_LATENCY)))
		else $error("ov does not match iv delayed by the pipeline latency");

endmodule

//--- des_tb.sv
// ---------------------------------------------------------------------------
// expects the key to stay constant until ov has returned the last block sent
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module des_tb;
	import des_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;
	localparam int NUM_PAIRS = 32;
	localparam int BUBBLE_CYCLES = 40;

	typedef struct packed {
		block_t key;
		block_t pt;
		block_t ct;
	} vector_t;

	localparam vector_t KAT [4] = '{
		'{64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405},
		'{64'h0000000000000000, 64'h0000000000000000, 64'h8CA64DE9C1B123A7},
		'{64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF, 64'h7359B2163E4EDC58},
		'{64'h0123456789ABCDEF, 64'h4E6F772069732074, 64'h3FA40E8A984D4815}
	};

	logic   clock;
	logic   rst;
	block_t key;
	block_t plaintext;
	logic   iv;
	block_t ciphertext;
	logic   ov;
	int     errors;
	int     tests_passed;
	int     tests_failed;

	des_top i_dut (
		.clock      (clock),
		.rst        (rst),
		.key        (key),
		.plaintext  (plaintext),
		.iv         (iv),
		.ciphertext (ciphertext),
		.ov         (ov)
	);

	bind des_top des_assert i_assert (
		.clock      (clock),
		.rst        (rst),
		.iv         (iv),
		.ov         (ov),
		.ciphertext (ciphertext)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic check_block(input block_t got, input block_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("%0t ns: %s passed", $time, name);
		end else begin
			tests_failed++;
			$display("%0t ns: %s failed with %0d errors", $time, name, errors - errors_before);
		end
	endtask

	// the first edge also ends any iv burst in progress
	task automatic wait_for_ov(output int latency);
		latency = 0;
		do begin
			@(posedge clock);
			iv <= 1'b0;
			latency++;
			@(negedge clock);
		end while (!ov && latency < TIMEOUT_CYCLES);
		if (!ov) begin
			$display("timeout: ov did not rise within %0d cycles", TIMEOUT_CYCLES);
			errors++;
		end
	endtask

	task automatic encrypt_single(input block_t k, input block_t pt, output block_t ct,
			output int latency);
		@(posedge clock);
		key       <= k;
		plaintext <= pt;
		iv        <= 1'b1;
		wait_for_ov(latency);
		ct = ciphertext;
	endtask

	initial begin
		block_t ref_ct [4];
		block_t ct;
		block_t ct_inv;
		block_t k;
		block_t pt;
		logic   pattern [BUBBLE_CYCLES];
		int     latency;
		int     start_errors;
		int     iv_pulses;
		int     ov_pulses;

		void'($urandom(91956));
		rst = 1'b1;
		key = '0;
		plaintext = '0;
		iv = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;

		start_errors = errors;
		for (int i = 0; i < 25; i++) begin
			@(negedge clock);
			check_valid(ov, 1'b0, "ov after reset");
			if (i == 0) begin
				check_block(ciphertext, '0, "ciphertext after reset");
			end
		end
		end_test("reset", start_errors);

		start_errors = errors;
		for (int i = 0; i < 4; i++) begin
			encrypt_single(KAT[i].key, KAT[i].pt, ct, latency);
			check_block(ct, KAT[i].ct, "known answer ciphertext");
			check_count(latency, PIPE_LATENCY, "known answer latency");
		end
		end_test("known answers", start_errors);

		// reference results come from the same plaintexts sent one at a time
		start_errors = errors;
		for (int i = 0; i < 4; i++) begin
			encrypt_single(KAT[0].key, KAT[i].pt, ref_ct[i], latency);
		end
		check_block(ref_ct[0], KAT[0].ct, "single run reference");
		for (int i = 0; i < 4; i++) begin
			@(posedge clock);
			key       <= KAT[0].key;
			plaintext <= KAT[i].pt;
			iv        <= 1'b1;
		end
		wait_for_ov(latency);
		check_count(latency, PIPE_LATENCY - 3, "burst latency");
		for (int i = 0; i < 4; i++) begin
			if (i > 0) begin
				@(negedge clock);
			end
			check_valid(ov, 1'b1, "ov during burst");
			check_block(ciphertext, ref_ct[i], "burst ciphertext");
		end
		@(negedge clock);
		check_valid(ov, 1'b0, "ov after burst");
		end_test("back-to-back throughput", start_errors);

		// E(~k, ~p) == ~E(k, p)
		start_errors = errors;
		for (int i = 0; i < NUM_PAIRS; i++) begin
			k = {$urandom, $urandom};
			pt = {$urandom, $urandom};
			encrypt_single(k, pt, ct, latency);
			encrypt_single(~k, ~pt, ct_inv, latency);
			check_block(ct_inv, ~ct, "complement ciphertext");
		end
		end_test("complementation", start_errors);

		start_errors = errors;
		k = {$urandom, $urandom};
		iv_pulses = 0;
		ov_pulses = 0;
		for (int i = 0; i < BUBBLE_CYCLES; i++) begin
			pattern[i] = 1'($urandom % 2);
			iv_pulses += int'(pattern[i]);
		end
		for (int i = 0; i < BUBBLE_CYCLES + PIPE_LATENCY; i++) begin
			@(posedge clock);
			key       <= k;
			plaintext <= {$urandom, $urandom};
			iv        <= (i < BUBBLE_CYCLES) ? pattern[i] : 1'b0;
			@(negedge clock);
			if (ov) begin
				ov_pulses++;
			end
			if (i >= PIPE_LATENCY) begin
				check_valid(ov, pattern[i-PIPE_LATENCY], "ov in bubble pattern");
			end else begin
				check_valid(ov, 1'b0, "ov before bubble pattern");
			end
		end
		check_count(ov_pulses, iv_pulses, "ov pulse count");
		end_test("valid bubbles", start_errors);

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
des_pkg.sv
des_key_schedule.sv
des_feistel.sv
des_round.sv
des_ip_stage.sv
des_fp_stage.sv
des_top.sv
des_assert.sv
des_tb.sv

//--- Bender.yml
package:
  name: des_pipeline

sources:
  - des_pkg.sv
  - des_key_schedule.sv
  - des_feistel.sv
  - des_round.sv
  - des_ip_stage.sv
  - des_fp_stage.sv
  - des_top.sv
  - target: test
    files:
      - des_assert.sv
      - des_tb.sv
